// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP       := tb_cache_bank
RTL_TOP   := cache_bank_top
FILELIST  := cache_bank_top.f
OBJ_DIR   := obj_dir
SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/tb_mem_model.svh

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== cache_bank_top.f ====
+incdir+include
hdl/cache_pkg.sv
hdl/access_queue.sv
hdl/line_store.sv
hdl/miss_tracker.sv
hdl/bank_ctrl.sv
hdl/cache_bank_top.sv
tb/tb_cache_bank.sv

// ==== hdl/access_queue.sv ====
`timescale 1ns/1ns

module access_queue #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 8
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     empty,
  output logic     full
);

  payload_t                     mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0]   count_q;
  logic                         do_push;
  logic                         do_pop;

  assign empty   = (count_q == '0);
  assign full    = (count_q == $bits(count_q)'(DEPTH));
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = mem_q[rd_ptr_q];

  // Storage, written at the tail
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        if (wr_ptr_q == $bits(wr_ptr_q)'(DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (do_pop) begin
        if (rd_ptr_q == $bits(rd_ptr_q)'(DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // Simultaneous push and pop keep the count
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Producer must hold off while full
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    full |-> !push);

  // Consumer pops only a valid head
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
    empty |-> !pop);

endmodule

// ==== hdl/bank_ctrl.sv ====
`timescale 1ns/1ns

module bank_ctrl (
  input  logic                               clk,
  input  logic                               arst_n,
  input  cache_pkg::bank_req_t               head,
  input  logic                               empty,
  output logic                               pop,
  output logic [cache_pkg::ADDR_W-1:0]       lookup_addr,
  input  logic                               hit,
  input  logic [cache_pkg::WAY_W-1:0]        hit_way,
  input  cache_pkg::line_t                   hit_line,
  output logic                               wr_en,
  output logic [cache_pkg::WAY_W-1:0]        wr_way,
  output logic [cache_pkg::LINE_BYTES-1:0]   wr_mask,
  output cache_pkg::line_t                   wr_data,
  output logic [cache_pkg::LINE_ADDR_W-1:0]  match_line_addr,
  input  logic                               pending,
  input  logic                               full,
  output logic                               alloc,
  input  logic                               fill_valid,
  output logic                               rsp_valid,
  output cache_pkg::bank_rsp_t               rsp,
  output logic                               wr_done,
  output logic                               miss_valid,
  output logic [cache_pkg::ID_W-1:0]         miss_id,
  output logic                               mem_valid,
  output cache_pkg::mem_req_t                mem_req
);

  import cache_pkg::*;

  logic [LINE_ADDR_W-1:0] line_addr;
  logic                   rd_hit;
  logic                   rd_miss;
  logic                   new_miss;
  logic                   stall;

  assign line_addr       = head.addr[ADDR_W-1:OFFSET_W];
  assign lookup_addr     = head.addr;
  assign match_line_addr = line_addr;

  // Classify the head
  assign rd_hit   = !head.write && hit;
  assign rd_miss  = !head.write && !hit;
  assign new_miss = rd_miss && !pending;
  assign stall    = new_miss && full;

  // Fills own the store for their cycle
  assign pop   = !empty && !fill_valid && !stall;
  assign alloc = pop && new_miss;

  // Reads touch the hit way with no bytes so the LRU bit follows
  assign wr_en   = pop && hit;
  assign wr_way  = hit_way;
  assign wr_mask = head.write ? head.mask : '0;
  assign wr_data = head.data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid  <= 1'b0;
      wr_done    <= 1'b0;
      miss_valid <= 1'b0;
      mem_valid  <= 1'b0;
    end else begin
      rsp_valid  <= pop && rd_hit;
      wr_done    <= pop && head.write;
      miss_valid <= pop && rd_miss;
      mem_valid  <= (pop && head.write) || alloc;
    end
  end

  // Payloads follow the strobes
  always_ff @(posedge clk) begin
    if (pop) begin
      rsp.id            <= head.id;
      rsp.addr          <= head.addr;
      rsp.data          <= hit_line;
      miss_id           <= head.id;
      mem_req.write     <= head.write;
      mem_req.line_addr <= line_addr;
      mem_req.data      <= head.write ? head.data : '0;
      mem_req.mask      <= head.write ? head.mask : '0;
    end
  end

endmodule

// ==== hdl/cache_bank_top.sv ====
`timescale 1ns/1ns

module cache_bank_top (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               req_valid,
  input  cache_pkg::bank_req_t               req,
  output logic                               aq_full,
  output logic                               rsp_valid,
  output cache_pkg::bank_rsp_t               rsp,
  output logic                               wr_done,
  output logic                               miss_valid,
  output logic [cache_pkg::ID_W-1:0]         miss_id,
  output logic                               mem_valid,
  output cache_pkg::mem_req_t                mem_req,
  input  logic                               fill_valid,
  input  logic [cache_pkg::LINE_ADDR_W-1:0]  fill_line_addr,
  input  cache_pkg::line_t                   fill_data
);

  import cache_pkg::*;

  bank_req_t              aq_head;
  logic                   aq_empty;
  logic                   aq_pop;

  logic [ADDR_W-1:0]      lookup_addr;
  logic                   hit;
  logic [WAY_W-1:0]       hit_way;
  line_t                  hit_line;
  logic                   wr_en;
  logic [WAY_W-1:0]       wr_way;
  logic [LINE_BYTES-1:0]  wr_mask;
  line_t                  wr_data;

  logic [LINE_ADDR_W-1:0] match_line_addr;
  logic                   mt_pending;
  logic                   mt_full;
  logic                   mt_alloc;

  access_queue #(
    .payload_t (bank_req_t),
    .DEPTH     (AQ_DEPTH)
  ) u_access_queue (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (req_valid),
    .push_data (req),
    .pop       (aq_pop),
    .head      (aq_head),
    .empty     (aq_empty),
    .full      (aq_full)
  );

  line_store u_line_store (
    .clk            (clk),
    .arst_n         (arst_n),
    .lookup_addr    (lookup_addr),
    .hit            (hit),
    .hit_way        (hit_way),
    .hit_line       (hit_line),
    .wr_en          (wr_en),
    .wr_way         (wr_way),
    .wr_mask        (wr_mask),
    .wr_data        (wr_data),
    .fill_valid     (fill_valid),
    .fill_line_addr (fill_line_addr),
    .fill_data      (fill_data)
  );

  miss_tracker u_miss_tracker (
    .clk             (clk),
    .arst_n          (arst_n),
    .match_line_addr (match_line_addr),
    .pending         (mt_pending),
    .full            (mt_full),
    .alloc           (mt_alloc),
    .fill_valid      (fill_valid),
    .fill_line_addr  (fill_line_addr)
  );

  bank_ctrl u_bank_ctrl (
    .clk             (clk),
    .arst_n          (arst_n),
    .head            (aq_head),
    .empty           (aq_empty),
    .pop             (aq_pop),
    .lookup_addr     (lookup_addr),
    .hit             (hit),
    .hit_way         (hit_way),
    .hit_line        (hit_line),
    .wr_en           (wr_en),
    .wr_way          (wr_way),
    .wr_mask         (wr_mask),
    .wr_data         (wr_data),
    .match_line_addr (match_line_addr),
    .pending         (mt_pending),
    .full            (mt_full),
    .alloc           (mt_alloc),
    .fill_valid      (fill_valid),
    .rsp_valid       (rsp_valid),
    .rsp             (rsp),
    .wr_done         (wr_done),
    .miss_valid      (miss_valid),
    .miss_id         (miss_id),
    .mem_valid       (mem_valid),
    .mem_req         (mem_req)
  );

endmodule

// ==== hdl/cache_pkg.sv ====
package cache_pkg;

  // Address split: tag 14:6, index 5:4, offset 3:0
  localparam int ADDR_W      = 15;
  localparam int LINE_BYTES  = 16;
  localparam int OFFSET_W    = 4;
  localparam int NUM_SETS    = 4;
  localparam int INDEX_W     = 2;
  localparam int NUM_WAYS    = 2;
  localparam int WAY_W       = $clog2(NUM_WAYS);
  localparam int TAG_W       = 9;
  localparam int LINE_ADDR_W = 11;

  // Requester tag, same width as the PTC id
  localparam int ID_W = 7;

  localparam int AQ_DEPTH    = 8;
  localparam int MSHR_DEPTH  = 4;
  localparam int MSHR_IDX_W  = $clog2(MSHR_DEPTH);

  typedef logic [LINE_BYTES*8-1:0] line_t;

  typedef struct packed {
    logic [ID_W-1:0]       id;
    logic                  write;
    logic [ADDR_W-1:0]     addr;
    line_t                 data;
    logic [LINE_BYTES-1:0] mask;
  } bank_req_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    line_t             data;
  } bank_rsp_t;

  // One line per memory transfer; mask only used by writes
  typedef struct packed {
    logic                   write;
    logic [LINE_ADDR_W-1:0] line_addr;
    line_t                  data;
    logic [LINE_BYTES-1:0]  mask;
  } mem_req_t;

endpackage

// ==== hdl/line_store.sv ====
`timescale 1ns/1ns

module line_store (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic [cache_pkg::ADDR_W-1:0]        lookup_addr,
  output logic                                hit,
  output logic [cache_pkg::WAY_W-1:0]         hit_way,
  output cache_pkg::line_t                    hit_line,
  input  logic                                wr_en,
  input  logic [cache_pkg::WAY_W-1:0]         wr_way,
  input  logic [cache_pkg::LINE_BYTES-1:0]    wr_mask,
  input  cache_pkg::line_t                    wr_data,
  input  logic                                fill_valid,
  input  logic [cache_pkg::LINE_ADDR_W-1:0]   fill_line_addr,
  input  cache_pkg::line_t                    fill_data
);

  import cache_pkg::*;

  line_t               data_q  [NUM_SETS][NUM_WAYS];
  logic [TAG_W-1:0]    tag_q   [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
  logic [WAY_W-1:0]    lru_q   [NUM_SETS];

  logic [INDEX_W-1:0]  lk_idx;
  logic [TAG_W-1:0]    lk_tag;
  logic [NUM_WAYS-1:0] way_hit;

  logic [INDEX_W-1:0]  fill_idx;
  logic [TAG_W-1:0]    fill_tag;
  logic [NUM_WAYS-1:0] fill_match;
  logic [WAY_W-1:0]    fill_way;

  assign lk_idx = lookup_addr[OFFSET_W +: INDEX_W];
  assign lk_tag = lookup_addr[ADDR_W-1 -: TAG_W];

  assign fill_idx = fill_line_addr[INDEX_W-1:0];
  assign fill_tag = fill_line_addr[LINE_ADDR_W-1 -: TAG_W];

  // Compare both ways of the set
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w]    = valid_q[lk_idx][w] && (tag_q[lk_idx][w] == lk_tag);
      fill_match[w] = valid_q[fill_idx][w] && (tag_q[fill_idx][w] == fill_tag);
    end
  end

  assign hit      = |way_hit;
  assign hit_way  = way_hit[1];
  assign hit_line = data_q[lk_idx][hit_way];

  // Refill of a present line lands in the same way
  assign fill_way = (|fill_match) ? fill_match[1] : lru_q[fill_idx];

  always_ff @(posedge clk) begin
    if (fill_valid) begin
      data_q[fill_idx][fill_way] <= fill_data;
      tag_q[fill_idx][fill_way]  <= fill_tag;
    end else if (wr_en) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (wr_mask[b]) begin
          data_q[lk_idx][wr_way][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // LRU bit names the way to replace next
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        lru_q[s]   <= '0;
      end
    end else if (fill_valid) begin
      valid_q[fill_idx][fill_way] <= 1'b1;
      lru_q[fill_idx]             <= ~fill_way;
    end else if (wr_en) begin
      lru_q[lk_idx] <= ~wr_way;
    end
  end

  // Fills never leave a duplicate tag in a set
  a_one_way_hits: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(way_hit));

endmodule

// ==== hdl/miss_tracker.sv ====
`timescale 1ns/1ns

module miss_tracker (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic [cache_pkg::LINE_ADDR_W-1:0]  match_line_addr,
  output logic                               pending,
  output logic                               full,
  input  logic                               alloc,
  input  logic                               fill_valid,
  input  logic [cache_pkg::LINE_ADDR_W-1:0]  fill_line_addr
);

  import cache_pkg::*;

  logic [MSHR_DEPTH-1:0]  valid_q;
  logic [LINE_ADDR_W-1:0] addr_q [MSHR_DEPTH];
  logic [MSHR_DEPTH-1:0]  match;
  logic [MSHR_DEPTH-1:0]  fill_hit;
  logic [MSHR_IDX_W-1:0]  free_idx;
  logic                   free_found;

  always_comb begin
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      match[i]    = valid_q[i] && (addr_q[i] == match_line_addr);
      fill_hit[i] = valid_q[i] && (addr_q[i] == fill_line_addr);
    end
  end

  assign pending = |match;
  assign full    = &valid_q;

  // Lowest free entry
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      if (!valid_q[i] && !free_found) begin
        free_found = 1'b1;
        free_idx   = MSHR_IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc && free_found) begin
      addr_q[free_idx] <= match_line_addr;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else begin
      if (fill_valid) begin
        valid_q <= valid_q & ~fill_hit;
      end
      if (alloc && free_found) begin
        valid_q[free_idx] <= 1'b1;
      end
    end
  end

  // Controller stalls a new miss while the table is full
  a_no_alloc_full: assert property (@(posedge clk) disable iff (!arst_n)
    alloc |-> !full);

  // A second read of a pending line merges instead
  a_no_alloc_dup: assert property (@(posedge clk) disable iff (!arst_n)
    alloc |-> !pending);

endmodule

// ==== include/tb_mem_model.svh ====
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

  // Byte-wide backing memory for the whole address space
  logic [7:0] model_mem [1 << ADDR_W];

  // Power-up contents, every address bit takes part
  function automatic logic [7:0] init_byte(input logic [ADDR_W-1:0] a);
    return a[7:0] ^ {a[ADDR_W-1:8], 1'b0} ^ 8'h3c;
  endfunction

  task automatic model_init();
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      model_mem[a] = init_byte(ADDR_W'(a));
    end
  endtask

  // Expected line contents at this moment
  function automatic line_t model_line(input logic [LINE_ADDR_W-1:0] la);
    line_t l;
    for (int b = 0; b < LINE_BYTES; b++) begin
      l[8*b +: 8] = model_mem[{la, OFFSET_W'(b)}];
    end
    return l;
  endfunction

  function automatic line_t merge_line(input line_t old_line, input line_t data,
                                       input logic [LINE_BYTES-1:0] mask);
    line_t l;
    l = old_line;
    for (int b = 0; b < LINE_BYTES; b++) begin
      if (mask[b]) begin
        l[8*b +: 8] = data[8*b +: 8];
      end
    end
    return l;
  endfunction

  task automatic apply_write(input logic [LINE_ADDR_W-1:0] la, input line_t data,
                             input logic [LINE_BYTES-1:0] mask);
    line_t l;
    l = merge_line(model_line(la), data, mask);
    for (int b = 0; b < LINE_BYTES; b++) begin
      model_mem[{la, OFFSET_W'(b)}] = l[8*b +: 8];
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

`endif

// ==== tb/tb_cache_bank.sv ====
`timescale 1ns/1ns

module tb_cache_bank;

  import cache_pkg::*;

  `include "tb_mem_model.svh"

  localparam logic [31:0] SEED    = 32'hd0cb_99af;
  localparam int          NUM_IDS = 1 << ID_W;
  localparam int          NUM_LINES = 1 << LINE_ADDR_W;

  logic                   clk = 1'b0;
  logic                   arst_n = 1'b0;
  logic                   req_valid = 1'b0;
  bank_req_t              req = '0;
  logic                   aq_full;
  logic                   rsp_valid;
  bank_rsp_t              rsp;
  logic                   wr_done;
  logic                   miss_valid;
  logic [ID_W-1:0]        miss_id;
  logic                   mem_valid;
  mem_req_t               mem_req;
  logic                   fill_valid = 1'b0;
  logic [LINE_ADDR_W-1:0] fill_line_addr = '0;
  line_t                  fill_data = '0;

  logic [31:0] lfsr_q = SEED;
  int          cycle = 0;
  int          error_count = 0;
  int          gen_left = 0;
  int          n_mem_reads = 0;
  bit          hold_fills = 1'b0;
  bit          pushed_last = 1'b0;
  bit          aq_full_seen = 1'b0;
  bit          busy [NUM_IDS];
  bit          filled_once [NUM_LINES];

  bank_req_t              push_q [$];
  bank_req_t              exp_q [$];
  bank_req_t              retry_q [$];
  logic [LINE_ADDR_W-1:0] pend_lines [$];
  logic [LINE_ADDR_W-1:0] fill_line_q [$];
  int                     fill_due_q [$];

  cache_bank_top u_cache_bank_top (
    .clk            (clk),
    .arst_n         (arst_n),
    .req_valid      (req_valid),
    .req            (req),
    .aq_full        (aq_full),
    .rsp_valid      (rsp_valid),
    .rsp            (rsp),
    .wr_done        (wr_done),
    .miss_valid     (miss_valid),
    .miss_id        (miss_id),
    .mem_valid      (mem_valid),
    .mem_req        (mem_req),
    .fill_valid     (fill_valid),
    .fill_line_addr (fill_line_addr),
    .fill_data      (fill_data)
  );

  always #4 clk = ~clk;

  // One new LFSR bit per step
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic line_t rand_line();
    line_t l;
    for (int w = 0; w < 4; w++) begin
      l[32*w +: 32] = take_bits(32);
    end
    return l;
  endfunction

  function automatic bit line_pending(input logic [LINE_ADDR_W-1:0] la);
    foreach (pend_lines[i]) begin
      if (pend_lines[i] == la) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Oldest unretired request may have been popped in the last cycle
  function automatic bit write_at_head(input logic [LINE_ADDR_W-1:0] la);
    if (exp_q.size() == 0) begin
      return 1'b0;
    end
    return exp_q[0].write && (exp_q[0].addr[ADDR_W-1:OFFSET_W] == la);
  endfunction

  function automatic int find_free_id();
    for (int i = 0; i < NUM_IDS; i++) begin
      if (!busy[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic bit all_quiet();
    if (push_q.size() != 0 || retry_q.size() != 0 || exp_q.size() != 0) begin
      return 1'b0;
    end
    if (fill_line_q.size() != 0 || gen_left != 0) begin
      return 1'b0;
    end
    foreach (busy[i]) begin
      if (busy[i]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("ERROR time %0t %s got %h expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic fail_run(input string what);
    error_count++;
    $display("Check failed at time %0t: %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "%s", what);
  endtask

  task automatic queue_req(input bit write, input logic [ADDR_W-1:0] addr,
                           input line_t data, input logic [LINE_BYTES-1:0] mask);
    bank_req_t r;
    int        id;
    id = find_free_id();
    if (id < 0) begin
      fail_run("no free request id");
    end
    busy[id] = 1'b1;
    r.id = ID_W'(id);
    r.write = write;
    r.addr = addr;
    r.data = write ? data : '0;
    r.mask = write ? mask : '0;
    push_q.push_back(r);
  endtask

  // Few tags over all four sets, so sets overflow their two ways
  task automatic make_random();
    bit          wr;
    logic [1:0]  t;
    logic [1:0]  idx;
    logic [3:0]  off;
    line_t       d;
    logic [15:0] m;
    wr = (take_bits(2) == 0);
    t = 2'(take_bits(2));
    idx = 2'(take_bits(2));
    off = 4'(take_bits(4));
    d = rand_line();
    m = 16'(take_bits(16));
    queue_req(wr, {7'h28, t, idx, off}, d, m);
  endtask

  task automatic drop_pending(input logic [LINE_ADDR_W-1:0] la);
    foreach (pend_lines[i]) begin
      if (pend_lines[i] == la) begin
        pend_lines.delete(i);
        return;
      end
    end
  endtask

  // Sample point away from both clock edges
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_retired(input int max_cycles);
    int n;
    n = 0;
    while (!all_quiet()) begin
      step();
      n++;
      if (n > max_cycles) begin
        fail_run("timeout waiting for all requests to retire");
      end
    end
  endtask

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while (push_q.size() != 0 || exp_q.size() != 0) begin
      step();
      n++;
      if (n > max_cycles) begin
        fail_run("timeout waiting for pushed requests to leave the queue");
      end
    end
  endtask

  task automatic wait_stalled(input int reads, input int max_cycles);
    int n;
    n = 0;
    while (n_mem_reads != reads || exp_q.size() != 1 || push_q.size() != 0) begin
      step();
      n++;
      if (n > max_cycles) begin
        fail_run("timeout waiting for the miss tracker to fill up");
      end
    end
  endtask

  // Producer and memory responder
  always @(posedge clk) begin : stimulus
    bank_req_t r;
    bit        have;
    logic [LINE_ADDR_W-1:0] la;
    fill_valid <= 1'b0;
    req_valid <= 1'b0;
    if (arst_n) begin
      cycle++;
      // A write to the line that may already be at memory goes first
      if (!hold_fills && fill_line_q.size() > 0) begin
        la = fill_line_q[0];
        if (cycle >= fill_due_q[0] && !write_at_head(la)) begin
          fill_valid <= 1'b1;
          fill_line_addr <= la;
          fill_data <= model_line(la);
          void'(fill_line_q.pop_front());
          void'(fill_due_q.pop_front());
        end
      end
      have = 1'b0;
      // Every other cycle at most, so a stale full flag is still safe
      if (!aq_full_seen && !pushed_last) begin
        if (retry_q.size() > 0 && !line_pending(retry_q[0].addr[ADDR_W-1:OFFSET_W])) begin
          r = retry_q.pop_front();
          have = 1'b1;
        end else begin
          if (push_q.size() == 0 && gen_left > 0 && find_free_id() >= 0) begin
            make_random();
            gen_left--;
          end
          if (push_q.size() > 0) begin
            r = push_q.pop_front();
            have = 1'b1;
          end
        end
      end
      pushed_last = have;
      if (have) begin
        req_valid <= 1'b1;
        req <= r;
        exp_q.push_back(r);
      end
    end
  end

  // Requests retire in queue order
  always @(negedge clk) begin : compare
    bank_req_t              e;
    logic [LINE_ADDR_W-1:0] la;
    bit                     send_read;
    int                     outcomes;
    if (arst_n) begin
      aq_full_seen = aq_full;
      outcomes = int'(rsp_valid) + int'(wr_done) + int'(miss_valid);
      if (outcomes > 1) begin
        fail_run("more than one outcome strobe in one cycle");
      end
      if (outcomes == 0) begin
        check_value("mem_valid", 128'(mem_valid), 128'(0));
      end else begin
        if (exp_q.size() == 0) begin
          fail_run("outcome strobe with no request outstanding");
        end
        e = exp_q.pop_front();
        la = e.addr[ADDR_W-1:OFFSET_W];
        if (rsp_valid) begin
          check_value("request write bit", 128'(e.write), 128'(0));
          if (!filled_once[la]) begin
            fail_run("read hit on a line that was never filled");
          end
          check_value("rsp.id", 128'(rsp.id), 128'(e.id));
          check_value("rsp.addr", 128'(rsp.addr), 128'(e.addr));
          check_value("rsp.data", rsp.data, model_line(la));
          busy[e.id] = 1'b0;
        end else if (wr_done) begin
          check_value("request write bit", 128'(e.write), 128'(1));
          check_value("mem_valid", 128'(mem_valid), 128'(1));
          check_value("mem_req.write", 128'(mem_req.write), 128'(1));
          check_value("mem_req.line_addr", 128'(mem_req.line_addr), 128'(la));
          check_value("mem_req.data", mem_req.data, e.data);
          check_value("mem_req.mask", 128'(mem_req.mask), 128'(e.mask));
          apply_write(la, e.data, e.mask);
          busy[e.id] = 1'b0;
        end else begin
          check_value("request write bit", 128'(e.write), 128'(0));
          check_value("miss_id", 128'(miss_id), 128'(e.id));
          // One memory read per line while it is outstanding
          send_read = !line_pending(la);
          check_value("mem_valid", 128'(mem_valid), 128'(send_read));
          if (send_read) begin
            check_value("mem_req.write", 128'(mem_req.write), 128'(0));
            check_value("mem_req.line_addr", 128'(mem_req.line_addr), 128'(la));
            if (pend_lines.size() >= MSHR_DEPTH) begin
              fail_run("memory read issued beyond the miss tracker depth");
            end
            pend_lines.push_back(la);
            fill_line_q.push_back(la);
            fill_due_q.push_back(cycle + 2 + int'(take_bits(5) % 19));
            n_mem_reads++;
          end
          retry_q.push_back(e);
        end
      end
      // Tracker entry is gone one edge after the fill
      if (fill_valid) begin
        drop_pending(fill_line_addr);
        filled_once[fill_line_addr] = 1'b1;
      end
    end
  end

  initial begin
    int base;
    model_init();
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("rsp_valid", 128'(rsp_valid), 128'(0));
    check_value("wr_done", 128'(wr_done), 128'(0));
    check_value("miss_valid", 128'(miss_valid), 128'(0));
    check_value("mem_valid", 128'(mem_valid), 128'(0));
    check_value("aq_full", 128'(aq_full), 128'(0));

    // Misses to one line merge into one memory read
    hold_fills = 1'b1;
    queue_req(1'b0, 15'h1234, '0, '0);
    queue_req(1'b0, 15'h1238, '0, '0);
    queue_req(1'b1, 15'h123c, rand_line(), 16'hf00f);
    queue_req(1'b0, 15'h1230, '0, '0);
    wait_drained(200);
    check_value("memory reads", 128'(n_mem_reads), 128'(1));
    hold_fills = 1'b0;
    wait_retired(2000);

    // Write hit, then a read of the merged line
    queue_req(1'b1, 15'h1236, rand_line(), 16'h0ff0);
    queue_req(1'b0, 15'h1230, '0, '0);
    wait_retired(2000);

    // Fifth distinct line stalls at the queue head
    hold_fills = 1'b1;
    base = n_mem_reads;
    for (int i = 0; i < 5; i++) begin
      queue_req(1'b0, {9'(9'h100 + i), 2'(i), 4'h8}, '0, '0);
    end
    wait_stalled(base + MSHR_DEPTH, 400);
    for (int i = 0; i < 30; i++) begin
      step();
    end
    check_value("memory reads", 128'(n_mem_reads), 128'(base + MSHR_DEPTH));
    check_value("stalled requests", 128'(exp_q.size()), 128'(1));
    hold_fills = 1'b0;
    wait_retired(4000);

    gen_left = 2000;
    wait_retired(400000);

    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
